// File: source/dpu_defines.svh
// Fixed sizes of the sequencer; changing them requires a matching edit of the layer ROM table
`ifndef DPU_DEFINES_SVH
`define DPU_DEFINES_SVH

// ==========================================================
// Feature-map storage
// ==========================================================

// Address width of one bank
`define DPU_ADDR_W 8

// Bytes per bank
`define DPU_BANK_BYTES 256

// ==========================================================
// Network shape
// ==========================================================

// Input image, one byte per pixel per channel
`define DPU_IMG_H 8
`define DPU_IMG_W 8

// Entries in the descriptor ROM
`define DPU_NUM_LAYERS 3

// Width of every channel or size field in a descriptor
`define DPU_DIM_W 4

`endif

// File: source/dpu_pkg.sv
// Shared types; all sizes come from dpu_defines.svh, and fmap_req_t carries one byte
`include "dpu_defines.svh"

package dpu_pkg;

    typedef logic [`DPU_ADDR_W-1:0] addr_t;
    typedef logic [`DPU_DIM_W-1:0]  dim_t;

    // Host command opcodes, value 5 is unused
    typedef enum logic [2:0] {
        CMD_WRITE     = 3'd0,
        CMD_RUN_LAYER = 3'd1,
        CMD_READ      = 3'd2,
        CMD_SET_LAYER = 3'd3,
        CMD_RUN_ALL   = 3'd4
    } cmd_op_e;

    typedef struct packed {
        cmd_op_e    op;
        addr_t      addr;
        logic [7:0] data;
    } cmd_t;

    typedef enum logic [1:0] {
        LK_NONE,
        LK_MAXPOOL,
        LK_SPLIT
    } layer_kind_e;

    typedef struct packed {
        layer_kind_e kind;
        dim_t        c_in;
        dim_t        c_out;
        dim_t        h_in;
        dim_t        w_in;
        dim_t        h_out;
        dim_t        w_out;
    } layer_desc_t;

    // One request into the bank pair; bank 0 is A
    typedef struct packed {
        logic              valid;
        logic              bank;
        logic              we;
        addr_t             addr;
        logic signed [7:0] wdata;
    } fmap_req_t;

    typedef enum logic [1:0] {
        SQ_IDLE,
        SQ_POOL,
        SQ_SPLIT
    } seq_state_e;

    typedef enum logic [2:0] {
        CS_IDLE,
        CS_ACK,
        CS_READ_WAIT,
        CS_RUN,
        CS_FINISH
    } ctrl_state_e;

endpackage

// File: source/layer_rom.sv
// Fixed three-layer table, purely combinational; index 3 returns an empty layer
`timescale 1ns/100ps
`include "dpu_defines.svh"

module layer_rom (
    input  logic [1:0]           layer,
    output dpu_pkg::layer_desc_t desc
);

    localparam dpu_pkg::dim_t IMG_H = dpu_pkg::dim_t'(`DPU_IMG_H);
    localparam dpu_pkg::dim_t IMG_W = dpu_pkg::dim_t'(`DPU_IMG_W);
    localparam dpu_pkg::dim_t CH_IN = dpu_pkg::dim_t'(4);
    localparam dpu_pkg::dim_t CH_SPLIT = dpu_pkg::dim_t'(2);

    always_comb begin
        case (layer)
            // Pool 8x8 to 4x4 over all input channels
            2'd0: desc = '{kind: dpu_pkg::LK_MAXPOOL,
                           c_in: CH_IN, c_out: CH_IN,
                           h_in: IMG_H, w_in: IMG_W,
                           h_out: IMG_H >> 1, w_out: IMG_W >> 1};
            // Keep the upper half of the channels
            2'd1: desc = '{kind: dpu_pkg::LK_SPLIT,
                           c_in: CH_IN, c_out: CH_SPLIT,
                           h_in: IMG_H >> 1, w_in: IMG_W >> 1,
                           h_out: IMG_H >> 1, w_out: IMG_W >> 1};
            2'd2: desc = '{kind: dpu_pkg::LK_MAXPOOL,
                           c_in: CH_SPLIT, c_out: CH_SPLIT,
                           h_in: IMG_H >> 1, w_in: IMG_W >> 1,
                           h_out: IMG_H >> 2, w_out: IMG_W >> 2};
            default: desc = '{kind: dpu_pkg::LK_NONE, default: '0};
        endcase
    end

endmodule

// File: source/host_cmd_ctrl.sv
// One command at a time with no back-pressure on responses; no bank request is made while busy
`timescale 1ns/100ps
`include "dpu_defines.svh"

module host_cmd_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_valid,
    input  dpu_pkg::cmd_t      cmd,
    output logic               cmd_ready,
    output logic               rsp_valid,
    output logic [7:0]         rsp_data,
    output logic               busy,
    output logic               done,
    output logic [1:0]         current_layer,
    output logic               seq_start,
    input  logic               layer_done,
    output logic               cur_bank,
    output dpu_pkg::fmap_req_t host_req,
    input  logic signed [7:0]  rd_data
);

    dpu_pkg::ctrl_state_e state;
    dpu_pkg::cmd_op_e     op_q;
    logic                 run_all_q;
    logic                 rd_pending;

    // ==========================================================
    // Command FSM
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= dpu_pkg::CS_IDLE;
            op_q          <= dpu_pkg::CMD_WRITE;
            cmd_ready     <= 1'b0;
            rsp_valid     <= 1'b0;
            busy          <= 1'b0;
            done          <= 1'b0;
            seq_start     <= 1'b0;
            current_layer <= 2'd0;
            cur_bank      <= 1'b0;
            run_all_q     <= 1'b0;
            rd_pending    <= 1'b0;
            host_req      <= '0;
        end else begin
            done           <= 1'b0;
            seq_start      <= 1'b0;
            host_req.valid <= 1'b0;
            // Bank data is ready one cycle after the read request
            rsp_valid      <= rd_pending;
            rd_pending     <= 1'b0;
            case (state)
                dpu_pkg::CS_IDLE: begin
                    cmd_ready <= 1'b1;
                    if (cmd_valid && cmd_ready) begin
                        cmd_ready <= 1'b0;
                        op_q      <= cmd.op;
                        state     <= dpu_pkg::CS_ACK;
                        case (cmd.op)
                            dpu_pkg::CMD_WRITE: host_req <= '{valid: 1'b1, bank: 1'b0,
                                we: 1'b1, addr: cmd.addr, wdata: cmd.data};
                            dpu_pkg::CMD_READ: begin
                                host_req <= '{valid: 1'b1, bank: cur_bank,
                                    we: 1'b0, addr: cmd.addr, wdata: '0};
                                state    <= dpu_pkg::CS_READ_WAIT;
                            end
                            dpu_pkg::CMD_SET_LAYER: current_layer <= cmd.data[1:0];
                            dpu_pkg::CMD_RUN_LAYER: run_all_q <= 1'b0;
                            dpu_pkg::CMD_RUN_ALL: begin
                                run_all_q     <= 1'b1;
                                current_layer <= 2'd0;
                                cur_bank      <= 1'b0;
                            end
                            default: ;
                        endcase
                    end
                end

                dpu_pkg::CS_ACK: begin
                    if (op_q == dpu_pkg::CMD_RUN_LAYER || op_q == dpu_pkg::CMD_RUN_ALL) begin
                        busy      <= 1'b1;
                        seq_start <= 1'b1;
                        state     <= dpu_pkg::CS_RUN;
                    end else begin
                        cmd_ready <= 1'b1;
                        state     <= dpu_pkg::CS_IDLE;
                    end
                end

                dpu_pkg::CS_READ_WAIT: begin
                    cmd_ready  <= 1'b1;
                    rd_pending <= 1'b1;
                    state      <= dpu_pkg::CS_IDLE;
                end

                // Result bank becomes the source of the next layer
                dpu_pkg::CS_RUN: begin
                    if (layer_done) begin
                        cur_bank <= ~cur_bank;
                        if (run_all_q && current_layer != 2'(`DPU_NUM_LAYERS - 1)) begin
                            current_layer <= current_layer + 2'd1;
                            seq_start     <= 1'b1;
                        end else begin
                            state <= dpu_pkg::CS_FINISH;
                        end
                    end
                end

                dpu_pkg::CS_FINISH: begin
                    busy      <= 1'b0;
                    done      <= 1'b1;
                    cmd_ready <= 1'b1;
                    state     <= dpu_pkg::CS_IDLE;
                end

                default: state <= dpu_pkg::CS_IDLE;
            endcase
        end
    end

    // Response byte holds until the next read
    always_ff @(posedge clk) begin
        if (rd_pending) begin
            rsp_data <= rd_data;
        end
    end

endmodule

// File: source/fmap_pingpong.sv
// Two 256-byte banks behind one port; contents are undefined until written
`timescale 1ns/100ps
`include "dpu_defines.svh"

module fmap_pingpong (
    input  logic               clk,
    input  dpu_pkg::fmap_req_t host_req,
    input  dpu_pkg::fmap_req_t seq_req,
    output logic signed [7:0]  rd_data
);

    logic signed [7:0] bank_a [`DPU_BANK_BYTES];
    logic signed [7:0] bank_b [`DPU_BANK_BYTES];

    dpu_pkg::fmap_req_t req;

    // Sequencer owns the port whenever it asks
    assign req = seq_req.valid ? seq_req : host_req;

    // ==========================================================
    // Write side, lands on the request edge
    // ==========================================================
    always_ff @(posedge clk) begin
        if (req.valid && req.we && !req.bank) begin
            bank_a[req.addr] <= req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid && req.we && req.bank) begin
            bank_b[req.addr] <= req.wdata;
        end
    end

    // ==========================================================
    // Read side, one cycle latency
    // ==========================================================
    always_ff @(posedge clk) begin
        if (req.valid && !req.we) begin
            if (req.bank) begin
                rd_data <= bank_b[req.addr];
            end else begin
                rd_data <= bank_a[req.addr];
            end
        end
    end

endmodule

// File: source/layer_sequencer.sv
// Serial walker: six cycles per pooled output and two per split byte; source and result banks differ
`timescale 1ns/100ps

module layer_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  dpu_pkg::layer_desc_t desc,
    input  logic                 src_bank,
    output dpu_pkg::fmap_req_t   seq_req,
    input  logic signed [7:0]    rd_data,
    output logic                 layer_done
);

    dpu_pkg::seq_state_e  state;
    dpu_pkg::layer_desc_t d_q;
    logic                 src_q;
    logic [2:0]           phase;
    dpu_pkg::dim_t        ch, oh, ow;
    dpu_pkg::addr_t       idx;
    logic signed [7:0]    max_q;
    dpu_pkg::addr_t       w_in, in_plane, out_plane, rd_addr, wr_addr, split_base, split_len;
    logic                 last_col, last_row, last_ch;

    // ==========================================================
    // Channel-major addressing
    // ==========================================================
    always_comb begin
        w_in       = dpu_pkg::addr_t'(d_q.w_in);
        in_plane   = dpu_pkg::addr_t'(d_q.h_in) * w_in;
        out_plane  = dpu_pkg::addr_t'(d_q.h_out) * dpu_pkg::addr_t'(d_q.w_out);
        // Window corner, phase bit 0 steps a column and bit 1 a row
        rd_addr    = dpu_pkg::addr_t'(ch) * in_plane + (dpu_pkg::addr_t'(oh) << 1) * w_in
                   + (dpu_pkg::addr_t'(ow) << 1) + (phase[1] ? w_in : '0)
                   + dpu_pkg::addr_t'(phase[0]);
        wr_addr    = dpu_pkg::addr_t'(ch) * out_plane
                   + dpu_pkg::addr_t'(oh) * dpu_pkg::addr_t'(d_q.w_out) + dpu_pkg::addr_t'(ow);
        split_base = dpu_pkg::addr_t'(d_q.c_out) * in_plane;
        split_len  = dpu_pkg::addr_t'(d_q.c_out) * out_plane;
        last_col   = (ow == d_q.w_out - 1'b1);
        last_row   = (oh == d_q.h_out - 1'b1);
        last_ch    = (ch == d_q.c_in - 1'b1);
    end

    // Reads from the source bank, writes to the other one
    always_comb begin
        seq_req      = '0;
        seq_req.bank = src_q;
        seq_req.addr = rd_addr;
        case (state)
            dpu_pkg::SQ_POOL: begin
                // Phase 4 only folds in the last byte
                seq_req.valid = (phase != 3'd4);
                if (phase == 3'd5) begin
                    seq_req.we    = 1'b1;
                    seq_req.bank  = ~src_q;
                    seq_req.addr  = wr_addr;
                    seq_req.wdata = max_q;
                end
            end
            dpu_pkg::SQ_SPLIT: begin
                seq_req.valid = 1'b1;
                seq_req.addr  = split_base + idx;
                if (phase[0]) begin
                    seq_req.we    = 1'b1;
                    seq_req.bank  = ~src_q;
                    seq_req.addr  = idx;
                    seq_req.wdata = rd_data;
                end
            end
            default: ;
        endcase
    end

    // ==========================================================
    // Loop control
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= dpu_pkg::SQ_IDLE;
            phase      <= '0;
            ch         <= '0;
            oh         <= '0;
            ow         <= '0;
            idx        <= '0;
            layer_done <= 1'b0;
        end else begin
            layer_done <= 1'b0;
            case (state)
                dpu_pkg::SQ_IDLE: begin
                    if (start) begin
                        phase <= '0;
                        ch    <= '0;
                        oh    <= '0;
                        ow    <= '0;
                        idx   <= '0;
                        case (desc.kind)
                            dpu_pkg::LK_MAXPOOL: state <= dpu_pkg::SQ_POOL;
                            dpu_pkg::LK_SPLIT:   state <= dpu_pkg::SQ_SPLIT;
                            default:             layer_done <= 1'b1;
                        endcase
                    end
                end
                dpu_pkg::SQ_POOL: begin
                    phase <= phase + 3'd1;
                    if (phase == 3'd5) begin
                        phase <= '0;
                        ow    <= last_col ? '0 : ow + 1'b1;
                        if (last_col) begin
                            oh <= last_row ? '0 : oh + 1'b1;
                            if (last_row) begin
                                ch <= ch + 1'b1;
                                if (last_ch) begin
                                    state      <= dpu_pkg::SQ_IDLE;
                                    layer_done <= 1'b1;
                                end
                            end
                        end
                    end
                end
                dpu_pkg::SQ_SPLIT: begin
                    phase <= {2'b00, ~phase[0]};
                    if (phase[0]) begin
                        idx <= idx + 1'b1;
                        if (idx == split_len - 1'b1) begin
                            state      <= dpu_pkg::SQ_IDLE;
                            layer_done <= 1'b1;
                        end
                    end
                end
                default: state <= dpu_pkg::SQ_IDLE;
            endcase
        end
    end

    // Descriptor latch and signed running maximum
    always_ff @(posedge clk) begin
        if (state == dpu_pkg::SQ_IDLE && start) begin
            d_q   <= desc;
            src_q <= src_bank;
        end
        if (state == dpu_pkg::SQ_POOL) begin
            if (phase == 3'd1) begin
                max_q <= rd_data;
            end else if (phase inside {3'd2, 3'd3, 3'd4} && rd_data > max_q) begin
                max_q <= rd_data;
            end
        end
    end

endmodule

// File: source/dpu_top.sv
// Byte-wide host port into a fixed three-layer pool and split network; responses cannot stall
`timescale 1ns/100ps

module dpu_top (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cmd_valid,
    input  dpu_pkg::cmd_t cmd,
    output logic          cmd_ready,
    output logic          rsp_valid,
    output logic [7:0]    rsp_data,
    output logic          busy,
    output logic          done,
    output logic [1:0]    current_layer
);

    dpu_pkg::layer_desc_t desc;
    dpu_pkg::fmap_req_t   host_req;
    dpu_pkg::fmap_req_t   seq_req;
    logic                 seq_start;
    logic                 layer_done;
    logic                 cur_bank;
    logic signed [7:0]    rd_data;

    host_cmd_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_ready     (cmd_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .busy          (busy),
        .done          (done),
        .current_layer (current_layer),
        .seq_start     (seq_start),
        .layer_done    (layer_done),
        .cur_bank      (cur_bank),
        .host_req      (host_req),
        .rd_data       (rd_data)
    );

    layer_rom u_rom (
        .layer (current_layer),
        .desc  (desc)
    );

    layer_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (seq_start),
        .desc       (desc),
        .src_bank   (cur_bank),
        .seq_req    (seq_req),
        .rd_data    (rd_data),
        .layer_done (layer_done)
    );

    fmap_pingpong u_fmap (
        .clk      (clk),
        .host_req (host_req),
        .seq_req  (seq_req),
        .rd_data  (rd_data)
    );

endmodule

// File: sim/dpu_asserts.sv
// Host-side protocol checks on the command controller; bound in from the testbench, idle in reset
`timescale 1ns/100ps

module dpu_asserts (
    input logic clk,
    input logic rst_n,
    input logic cmd_ready,
    input logic rsp_valid,
    input logic busy,
    input logic done
);

    // Number of failed assertions so far
    int fail_count = 0;

    // ==========================================================
    // Run and response protocol
    // ==========================================================

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fail_count++;
        end

    // No command is taken during a run
    a_ready_idle: assert property (@(posedge clk) disable iff (!rst_n) !(cmd_ready && busy))
        else begin
            $error("cmd_ready was high while busy was high");
            fail_count++;
        end

    a_rsp_idle: assert property (@(posedge clk) disable iff (!rst_n) !(rsp_valid && busy))
        else begin
            $error("rsp_valid pulsed while busy was high");
            fail_count++;
        end

endmodule

// File: sim/tb_dpu.sv
// Directed host-port tests; expects the fixed three-layer ROM and a simulator with timing
`timescale 1ns/100ps
`include "dpu_defines.svh"

module tb_dpu;

    // Tests take about 2500 cycles with two 256-byte image loads dominating
    // Limit sits well above four times that
    localparam int TIMEOUT_CYCLES = 20000;

    logic          clk;
    logic          rst_n;
    logic          cmd_valid;
    dpu_pkg::cmd_t cmd;
    logic          cmd_ready;
    logic          rsp_valid;
    logic [7:0]    rsp_data;
    logic          busy;
    logic          done;
    logic [1:0]    current_layer;

    // Reference model of both banks and the bank select
    logic signed [7:0] model_mem [2][`DPU_BANK_BYTES];
    logic              model_bank;
    logic [31:0]       lcg_state;
    int                cycles;
    int                done_pulses;
    int                checks;
    int                errors;
    int                test_errors;

    dpu_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_ready     (cmd_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .busy          (busy),
        .done          (done),
        .current_layer (current_layer)
    );

    bind host_cmd_ctrl dpu_asserts u_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_ready (cmd_ready),
        .rsp_valid (rsp_valid),
        .busy      (busy),
        .done      (done)
    );

    always #10 clk = ~clk;

    // Sampled away from the rising edge
    always @(negedge clk) begin
        if (done) begin
            done_pulses++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT never finished", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ==========================================================
    // Helpers
    // ==========================================================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic note_failure(input string msg);
        $display("%s", msg);
        test_errors++;
    endtask

    task automatic expect_true(input logic cond, input string msg);
        checks++;
        assert (cond) else note_failure(msg);
    endtask

    task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp) else
            note_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // Returns at 2 ns after the accepting edge
    task automatic send_cmd(input dpu_pkg::cmd_op_e op, input logic [7:0] addr,
                            input logic [7:0] data);
        while (!cmd_ready) begin
            @(posedge clk);
            #2;
        end
        cmd_valid = 1'b1;
        cmd       = '{op: op, addr: addr, data: data};
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
        expect_true(!cmd_ready, "cmd_ready stayed high after an accepted command");
    endtask

    // The response must appear on the second edge after acceptance
    task automatic read_byte(input logic [7:0] addr, output logic [7:0] data);
        send_cmd(dpu_pkg::CMD_READ, addr, 8'h00);
        @(posedge clk);
        #2;
        expect_true(!rsp_valid, $sformatf("Read of 0x%h answered one edge early", addr));
        @(posedge clk);
        #2;
        expect_true(rsp_valid, $sformatf("Read of 0x%h gave no response on the second edge", addr));
        data = rsp_data;
    endtask

    task automatic wait_done();
        while (!done) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic start_run(input dpu_pkg::cmd_op_e op);
        send_cmd(op, 8'h00, 8'h00);
        @(posedge clk);
        #2;
        expect_true(busy, "busy did not rise on the edge after a run command");
        wait_done();
        expect_true(!busy, "busy was still high with done");
    endtask

    task automatic set_layer(input logic [1:0] layer);
        send_cmd(dpu_pkg::CMD_SET_LAYER, 8'h00, {6'd0, layer});
    endtask

    task automatic fill_image();
        logic [7:0] b;
        for (int i = 0; i < `DPU_BANK_BYTES; i++) begin
            lcg_state = lcg_next(lcg_state);
            b = lcg_state[23:16];
            send_cmd(dpu_pkg::CMD_WRITE, 8'(i), b);
            model_mem[1'b0][8'(i)] = b;
        end
    endtask

    // Signed 2x2 stride-2 maximum per channel from the current bank into the other one
    task automatic apply_pool(input int nch, input int h, input int w);
        logic              src;
        logic signed [7:0] m;
        logic signed [7:0] v;
        src = model_bank;
        for (int c = 0; c < nch; c++) begin
            for (int oy = 0; oy < h / 2; oy++) begin
                for (int ox = 0; ox < w / 2; ox++) begin
                    m = model_mem[src][8'(c * h * w + 2 * oy * w + 2 * ox)];
                    for (int k = 1; k < 4; k++) begin
                        v = model_mem[src][8'(c * h * w + (2 * oy + k / 2) * w
                                              + 2 * ox + k % 2)];
                        if (v > m) begin
                            m = v;
                        end
                    end
                    model_mem[~src][8'(c * (h / 2) * (w / 2) + oy * (w / 2) + ox)] = m;
                end
            end
        end
        model_bank = ~src;
    endtask

    // Upper nkeep channels move to the bottom of the other bank
    task automatic apply_split(input int nkeep, input int h, input int w);
        logic src;
        src = model_bank;
        for (int i = 0; i < nkeep * h * w; i++) begin
            model_mem[~src][8'(i)] = model_mem[src][8'(nkeep * h * w + i)];
        end
        model_bank = ~src;
    endtask

    task automatic verify_bank(input int count);
        logic [7:0] got;
        logic [7:0] exp;
        for (int i = 0; i < count; i++) begin
            read_byte(8'(i), got);
            exp = model_mem[model_bank][8'(i)];
            compare_byte($sformatf("rsp_data[0x%h]", 8'(i)), got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed",
                 test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    // ==========================================================
    // Directed tests
    // ==========================================================
    task automatic check_after_reset();
        logic [7:0] got;
        compare_byte("busy", 8'(busy), 8'h00);
        compare_byte("done", 8'(done), 8'h00);
        compare_byte("rsp_valid", 8'(rsp_valid), 8'h00);
        compare_byte("current_layer", 8'(current_layer), 8'h00);
        compare_byte("cmd_ready", 8'(cmd_ready), 8'h01);
        send_cmd(dpu_pkg::CMD_WRITE, 8'h10, 8'ha5);
        model_mem[1'b0][8'h10] = 8'ha5;
        read_byte(8'h10, got);
        compare_byte("rsp_data[0x10]", got, 8'ha5);
        report_test("reset state");
    endtask

    task automatic single_pool_layer();
        int neg;
        fill_image();
        set_layer(2'd0);
        start_run(dpu_pkg::CMD_RUN_LAYER);
        apply_pool(4, 8, 8);
        verify_bank(64);
        neg = 0;
        for (int i = 0; i < 64; i++) begin
            if (model_mem[model_bank][8'(i)] < 0) begin
                neg++;
            end
        end
        expect_true(neg > 0, "No negative window maximum was exercised");
        report_test("single max-pool layer");
    endtask

    task automatic split_after_pool();
        set_layer(2'd1);
        start_run(dpu_pkg::CMD_RUN_LAYER);
        apply_split(2, 4, 4);
        verify_bank(32);
        report_test("split after pool");
    endtask

    task automatic full_network();
        int pulses_before;
        fill_image();
        model_bank = 1'b0;
        apply_pool(4, 8, 8);
        apply_split(2, 4, 4);
        apply_pool(2, 4, 4);
        pulses_before = done_pulses;
        start_run(dpu_pkg::CMD_RUN_ALL);
        repeat (4) @(posedge clk);
        #2;
        expect_true(done_pulses - pulses_before == 1,
                    $sformatf("Expected one done pulse, saw %0d", done_pulses - pulses_before));
        compare_byte("current_layer", 8'(current_layer), 8'h02);
        verify_bank(8);
        report_test("full network");
    endtask

    task automatic empty_layer();
        set_layer(2'd3);
        start_run(dpu_pkg::CMD_RUN_LAYER);
        model_bank = ~model_bank;
        compare_byte("current_layer", 8'(current_layer), 8'h03);
        verify_bank(64);
        report_test("empty layer");
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        model_bank  = 1'b0;
        lcg_state   = 32'hf43f;
        cycles      = 0;
        done_pulses = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        check_after_reset();
        single_pool_layer();
        split_after_pool();
        full_network();
        empty_layer();
        if (u_dut.u_ctrl.u_asserts.fail_count != 0) begin
            $display("Bound protocol assertions failed %0d times",
                     u_dut.u_ctrl.u_asserts.fail_count);
            errors += u_dut.u_ctrl.u_asserts.fail_count;
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+source
source/dpu_pkg.sv
source/layer_rom.sv
source/host_cmd_ctrl.sv
source/fmap_pingpong.sv
source/layer_sequencer.sv
source/dpu_top.sv
sim/dpu_asserts.sv
sim/tb_dpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dpu
RTL_TOP   ?= dpu_top
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FLIST     ?= files.f
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
PASS_MSG  := ALL CHECKS PASSED
SOURCES   := $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
